/* bench/retire_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_tb;

    localparam int rob_depth = 8;

    logic        itf;
    logic        rst_n;
    logic        disp_valid;
    logic [31:0] disp_inst;
    logic [31:0] disp_pc;
    logic        disp_full;
    logic [2:0]  disp_tag;
    logic        wb_valid;
    logic [2:0]  wb_tag;
    logic [31:0] wb_data;
    logic [31:0] wb_next_pc;
    logic        wb_mispredict;
    logic        retire_valid;
    logic [63:0] retire_order;
    logic [31:0] retire_inst;
    logic [31:0] retire_pc_rdata;
    logic [31:0] retire_pc_wdata;
    logic [4:0]  retire_rd_addr;
    logic [31:0] retire_rd_wdata;
    logic        retire_halt;
    logic        rf_we;
    logic [4:0]  rf_addr;
    logic [31:0] rf_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    // model entries by tag, order_q holds live tags oldest first
    logic [31:0] m_inst [rob_depth];
    logic [31:0] m_pc   [rob_depth];
    logic [31:0] m_data [rob_depth];
    logic [31:0] m_npc  [rob_depth];
    logic        m_mis  [rob_depth];
    logic        m_done [rob_depth];
    int          order_q [$];

    // stimulus knobs and bookkeeping
    int          disp_rate;
    logic        wb_enable;
    logic        mis_enable;
    logic        paused;
    logic        halt_pending;
    logic        halt_seen;
    logic        timed_out;
    logic [2:0]  mis_tag;
    logic [2:0]  tail_exp;
    logic [31:0] pc_next;
    logic [63:0] order_exp;
    int          mismatches;
    int          failures;

    retire_unit #(.rob_depth(rob_depth)) DUT (.*);

    initial begin
        itf = 1'b0;
        forever #5 itf = ~itf;
    end

    task automatic compare(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h, expected %h", name, act, exp);
        end
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("failure: %s", what);
    endtask

    // register, store or branch word; rd zero now and then
    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        w = $urandom;
        case ($urandom % 3)
            0: w[6:0] = 7'h23;
            1: w[6:0] = 7'h63;
            default: begin
                w[6:0] = 7'h33;
                if ($urandom % 6 == 0) w[11:7] = 5'd0;
            end
        endcase
        return w;
    endfunction

    // outputs of the edge just passed, compared against the model
    task automatic observe_outputs();
        int          t;
        logic [6:0]  op;
        logic [4:0]  rd_exp;
        logic [31:0] wd_exp;
        if (retire_valid) begin
            if (order_q.size() == 0) begin
                report_failure("an instruction retired with none outstanding");
            end else begin
                t = order_q.pop_front();
                if (!m_done[t]) report_failure("an instruction retired before its writeback");
                op = m_inst[t][6:0];
                // stores and branches carry immediate bits in the rd slot
                rd_exp = (op == 7'h23 || op == 7'h63) ? 5'd0 : m_inst[t][11:7];
                wd_exp = (rd_exp == 5'd0) ? 32'd0 : m_data[t];
                compare("retire_inst", retire_inst, m_inst[t]);
                compare("retire_pc_rdata", retire_pc_rdata, m_pc[t]);
                compare("retire_pc_wdata", retire_pc_wdata, m_npc[t]);
                compare("retire_order", retire_order, order_exp);
                compare("retire_rd_addr", retire_rd_addr, rd_exp);
                compare("retire_rd_wdata", retire_rd_wdata, wd_exp);
                compare("rf_we", rf_we, rd_exp != 5'd0);
                if (rd_exp != 5'd0) compare("rf_addr", rf_addr, rd_exp);
                if (rd_exp != 5'd0) compare("rf_data", rf_data, wd_exp);
                compare("retire_halt", retire_halt, m_inst[t] == 32'h00000063);
                compare("redirect_valid", redirect_valid, m_mis[t]);
                if (m_inst[t] == 32'h00000063) halt_seen = 1'b1;
                if (m_mis[t]) begin
                    compare("redirect_pc", redirect_pc, m_npc[t]);
                    // younger work is squashed, buffer restarts at slot zero
                    order_q.delete();
                    tail_exp = 3'd0;
                    pc_next  = m_npc[t];
                    paused   = 1'b0;
                end
            end
            order_exp++;
        end else begin
            compare("rf_we", rf_we, 1'b0);
            compare("redirect_valid", redirect_valid, 1'b0);
            compare("retire_halt", retire_halt, 1'b0);
        end
        if (order_q.size() > rob_depth) report_failure("model holds more entries than the buffer");
        compare("disp_full", disp_full, order_q.size() == rob_depth);
        compare("disp_tag", disp_tag, tail_exp);
    endtask

    // one clock: check, then drive writeback and dispatch 1 ns after the edge
    task automatic run_cycle();
        int          t;
        int          cand [$];
        logic [31:0] w;
        @(posedge itf);
        #1;
        observe_outputs();
        disp_valid    = 1'b0;
        wb_valid      = 1'b0;
        wb_mispredict = 1'b0;
        if (wb_enable && ($urandom % 4 != 0)) begin
            // while a mispredict waits only older tags may complete
            for (int i = 0; i < order_q.size(); i++) begin
                if (paused && order_q[i] == mis_tag) break;
                if (!m_done[order_q[i]]) cand.push_back(order_q[i]);
            end
            if (cand.size() > 0) begin
                t = cand[$urandom % cand.size()];
                m_done[t] = 1'b1;
                m_data[t] = $urandom;
                m_npc[t]  = m_pc[t] + 32'd4;
                m_mis[t]  = 1'b0;
                if (mis_enable && !paused && m_inst[t][6:0] == 7'h63 && $urandom % 5 == 0) begin
                    m_mis[t] = 1'b1;
                    m_npc[t] = $urandom & 32'hffff_fffc;
                    paused   = 1'b1;
                    mis_tag  = t;
                end
                wb_valid      = 1'b1;
                wb_tag        = t;
                wb_data       = m_data[t];
                wb_next_pc    = m_npc[t];
                wb_mispredict = m_mis[t];
            end
        end
        if (!paused && ($urandom % 8 < disp_rate)) begin
            w = halt_pending ? 32'h00000063 : random_inst();
            disp_valid = 1'b1;
            disp_inst  = w;
            disp_pc    = pc_next;
            // a full buffer drops the attempt
            if (!disp_full) begin
                order_q.push_back(tail_exp);
                m_inst[tail_exp] = w;
                m_pc[tail_exp]   = pc_next;
                m_done[tail_exp] = 1'b0;
                tail_exp         = tail_exp + 3'd1;
                pc_next          = pc_next + 32'd4;
                if (halt_pending) disp_rate = 0;
                halt_pending = 1'b0;
            end
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'hec7b383b));
        rst_n = 1'b0;
        disp_valid = 1'b0;
        disp_inst = '0;
        disp_pc = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        wb_next_pc = '0;
        wb_mispredict = 1'b0;
        {wb_enable, mis_enable, paused, halt_pending, halt_seen, timed_out} = '0;
        mis_tag = '0;
        tail_exp = '0;
        pc_next = 32'h0000_1000;
        order_exp = '0;
        mismatches = 0;
        failures = 0;
        disp_rate = 8;
        repeat (2) @(posedge itf);
        #1;
        rst_n = 1'b1;
        compare("disp_full", disp_full, 1'b0);
        compare("retire_valid", retire_valid, 1'b0);
        compare("rf_we", rf_we, 1'b0);
        compare("redirect_valid", redirect_valid, 1'b0);
        compare("retire_halt", retire_halt, 1'b0);
        // fill the buffer with no writeback, then push against full
        n = 0;
        while (order_q.size() < rob_depth && !timed_out) begin
            run_cycle();
            n++;
            if (n > 40) begin
                timed_out = 1'b1;
                report_failure("timeout while filling the buffer");
            end
        end
        repeat (3) run_cycle();
        compare("disp_full", disp_full, 1'b1);
        // random traffic with out of order writeback and mispredicts
        wb_enable  = 1'b1;
        mis_enable = 1'b1;
        disp_rate  = 5;
        if (!timed_out) repeat (800) run_cycle();
        mis_enable = 1'b0;
        n = 0;
        while (paused && !timed_out) begin
            run_cycle();
            n++;
            if (n > 200) begin
                timed_out = 1'b1;
                report_failure("timeout waiting for the mispredict redirect");
            end
        end
        // end of program marker, then drain
        halt_pending = 1'b1;
        disp_rate    = 8;
        n = 0;
        while (!halt_seen && !timed_out) begin
            run_cycle();
            n++;
            if (n > 300) begin
                timed_out = 1'b1;
                report_failure("timeout waiting for the halt to retire");
            end
        end
        // buffer is drained, nothing more may retire
        repeat (4) run_cycle();
        $display("mismatches: %0d, other failures: %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
logic/rv_isa_pkg.sv
logic/rob_pkg.sv
logic/reorder_buffer.sv
logic/retire_tracker.sv
logic/retire_unit.sv
bench/retire_tb.sv

/* logic/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                          itf,
    input  logic                          rst_n,

    // dispatch side, in program order
    input  logic                          disp_valid,
    input  rv_isa_pkg::inst_word_u        disp_inst,
    input  logic [rv_isa_pkg::xlen-1:0]   disp_pc,
    output logic                          disp_full,
    output logic [tag_w-1:0]              disp_tag,

    // writeback side, any order
    input  logic                          wb_valid,
    input  logic [tag_w-1:0]              wb_tag,
    input  logic [rv_isa_pkg::xlen-1:0]   wb_data,
    input  logic [rv_isa_pkg::xlen-1:0]   wb_next_pc,
    input  logic                          wb_mispredict,

    // head entry, combinational
    output logic                          commit_valid,
    output rv_isa_pkg::inst_word_u        commit_inst,
    output logic [rv_isa_pkg::xlen-1:0]   commit_pc,
    output logic [rv_isa_pkg::xlen-1:0]   commit_data,
    output logic [rv_isa_pkg::xlen-1:0]   commit_next_pc,
    output logic                          commit_mispredict
);

    // per-entry state bits
    logic [rob_depth-1:0]          valid_q;
    logic [rob_depth-1:0]          done_q;

    // entry payload
    rv_isa_pkg::inst_word_u        inst_q    [rob_depth];
    logic [rv_isa_pkg::xlen-1:0]   pc_q      [rob_depth];
    logic [rv_isa_pkg::xlen-1:0]   data_q    [rob_depth];
    logic [rv_isa_pkg::xlen-1:0]   next_pc_q [rob_depth];
    logic                          mispred_q [rob_depth];

    // pointers wrap on their own, depth is a power of two
    logic [tag_w-1:0]              head;
    logic [tag_w-1:0]              tail;

    // occupancy, one bit wider to hold rob_depth
    logic [tag_w:0]                count;

    logic                          do_disp;
    logic                          do_commit;
    logic                          flush;

    // tail slot still busy means tail caught up with head
    assign disp_full = valid_q[tail];
    assign disp_tag  = tail;

    assign do_disp   = disp_valid && !disp_full;
    assign do_commit = commit_valid;
    // committed mispredict drops everything younger
    assign flush     = do_commit && commit_mispredict;

    // head entry drives the commit port
    assign commit_valid      = valid_q[head] && done_q[head];
    assign commit_inst       = inst_q[head];
    assign commit_pc         = pc_q[head];
    assign commit_data       = data_q[head];
    assign commit_next_pc    = next_pc_q[head];
    assign commit_mispredict = mispred_q[head];

    // control state
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else if (flush) begin
            // back to an empty buffer at slot zero
            valid_q <= '0;
            done_q  <= '0;
            head    <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            // allocate at tail
            if (do_disp) begin
                valid_q[tail] <= 1'b1;
                done_q[tail]  <= 1'b0;
                tail          <= tail + 1'b1;
            end
            // result arrived for this tag
            if (wb_valid) begin
                done_q[wb_tag] <= 1'b1;
            end
            // retire head, last so it wins over a late writeback
            if (do_commit) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
                head          <= head + 1'b1;
            end
            unique case ({do_disp, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload, written on allocate and on writeback
    always_ff @(posedge itf) begin
        if (do_disp) begin
            inst_q[tail] <= disp_inst;
            pc_q[tail]   <= disp_pc;
        end
        if (wb_valid) begin
            data_q[wb_tag]    <= wb_data;
            next_pc_q[wb_tag] <= wb_next_pc;
            mispred_q[wb_tag] <= wb_mispredict;
        end
    end

    // occupancy bound
    a_count_bound: assert property (
        @(posedge itf) disable iff (!rst_n)
        count <= rob_depth
    );

    // writeback only for live entries
    a_wb_live_tag: assert property (
        @(posedge itf) disable iff (!rst_n)
        wb_valid |-> valid_q[wb_tag]
    );

    // pointer based full agrees with the counter
    a_full_count: assert property (
        @(posedge itf) disable iff (!rst_n)
        disp_full |-> (count == rob_depth)
    );

endmodule

`default_nettype wire

/* logic/retire_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_tracker (
    input  logic                              itf,
    input  logic                              rst_n,

    // commit from the buffer head
    input  logic                              commit_valid,
    input  rv_isa_pkg::inst_word_u            commit_inst,
    input  logic [rv_isa_pkg::xlen-1:0]       commit_pc,
    input  logic [rv_isa_pkg::xlen-1:0]       commit_data,
    input  logic [rv_isa_pkg::xlen-1:0]       commit_next_pc,
    input  logic                              commit_mispredict,

    // retirement record
    output logic                              retire_valid,
    output logic [rob_pkg::order_w-1:0]       retire_order,
    output logic [rv_isa_pkg::xlen-1:0]       retire_inst,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_rdata,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_wdata,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd_addr,
    output logic [rv_isa_pkg::xlen-1:0]       retire_rd_wdata,
    output logic                              retire_halt,

    // register file write
    output logic                              rf_we,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rf_addr,
    output logic [rv_isa_pkg::xlen-1:0]       rf_data,

    // front end redirect
    output logic                              redirect_valid,
    output logic [rv_isa_pkg::xlen-1:0]       redirect_pc
);

    logic                              no_rd;
    logic [rv_isa_pkg::reg_addr_w-1:0] rd;
    logic [rv_isa_pkg::xlen-1:0]       rd_wdata;
    logic [rob_pkg::order_w-1:0]       order_cnt;

    // s-type view, stores and branches have no rd
    // their bits 11:7 are imm_lo, not a register
    assign no_rd = (commit_inst.s.opcode == rv_isa_pkg::opc_store)
                || (commit_inst.s.opcode == rv_isa_pkg::opc_branch);

    // r-type view for everything else
    assign rd = no_rd ? '0 : commit_inst.r.rd;

    // x0 writes report zero data
    assign rd_wdata = (rd == '0) ? '0 : commit_data;

    // control part of the record
    always_ff @(posedge itf) begin
        if (!rst_n) begin
            retire_valid   <= 1'b0;
            retire_halt    <= 1'b0;
            rf_we          <= 1'b0;
            redirect_valid <= 1'b0;
            retire_order   <= '0;
            order_cnt      <= '0;
        end else begin
            retire_valid   <= commit_valid;
            retire_halt    <= commit_valid && (commit_inst == rob_pkg::halt_inst);
            rf_we          <= commit_valid && (rd != '0);
            redirect_valid <= commit_valid && commit_mispredict;
            // record takes the count, counter moves on
            if (commit_valid) begin
                retire_order <= order_cnt;
                order_cnt    <= order_cnt + 1'b1;
            end
        end
    end

    // data part, qualified by the valid bits above
    always_ff @(posedge itf) begin
        retire_inst     <= commit_inst;
        retire_pc_rdata <= commit_pc;
        // resolved next pc, equals the redirect target on a mispredict
        retire_pc_wdata <= commit_next_pc;
        retire_rd_addr  <= rd;
        retire_rd_wdata <= rd_wdata;
        rf_addr         <= rd;
        rf_data         <= rd_wdata;
        redirect_pc     <= commit_next_pc;
    end

    // record only follows a commit one cycle earlier
    a_retire_after_commit: assert property (
        @(posedge itf) disable iff (!rst_n)
        retire_valid |-> $past(commit_valid)
    );

endmodule

`default_nettype wire

/* logic/retire_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_unit #(
    parameter int rob_depth = 8,
    localparam int tag_w = $clog2(rob_depth)
) (
    input  logic                              itf,
    input  logic                              rst_n,

    // dispatch
    input  logic                              disp_valid,
    input  rv_isa_pkg::inst_word_u            disp_inst,
    input  logic [rv_isa_pkg::xlen-1:0]       disp_pc,
    output logic                              disp_full,
    output logic [tag_w-1:0]                  disp_tag,

    // writeback
    input  logic                              wb_valid,
    input  logic [tag_w-1:0]                  wb_tag,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_data,
    input  logic [rv_isa_pkg::xlen-1:0]       wb_next_pc,
    input  logic                              wb_mispredict,

    // retirement record
    output logic                              retire_valid,
    output logic [rob_pkg::order_w-1:0]       retire_order,
    output logic [rv_isa_pkg::xlen-1:0]       retire_inst,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_rdata,
    output logic [rv_isa_pkg::xlen-1:0]       retire_pc_wdata,
    output logic [rv_isa_pkg::reg_addr_w-1:0] retire_rd_addr,
    output logic [rv_isa_pkg::xlen-1:0]       retire_rd_wdata,
    output logic                              retire_halt,

    // register write and redirect
    output logic                              rf_we,
    output logic [rv_isa_pkg::reg_addr_w-1:0] rf_addr,
    output logic [rv_isa_pkg::xlen-1:0]       rf_data,
    output logic                              redirect_valid,
    output logic [rv_isa_pkg::xlen-1:0]       redirect_pc
);

    // head of buffer into the tracker
    logic                        commit_valid;
    rv_isa_pkg::inst_word_u      commit_inst;
    logic [rv_isa_pkg::xlen-1:0] commit_pc;
    logic [rv_isa_pkg::xlen-1:0] commit_data;
    logic [rv_isa_pkg::xlen-1:0] commit_next_pc;
    logic                        commit_mispredict;

    reorder_buffer #(
        .rob_depth(rob_depth)
    ) u_rob (
        .itf               (itf),
        .rst_n             (rst_n),
        .disp_valid        (disp_valid),
        .disp_inst         (disp_inst),
        .disp_pc           (disp_pc),
        .disp_full         (disp_full),
        .disp_tag          (disp_tag),
        .wb_valid          (wb_valid),
        .wb_tag            (wb_tag),
        .wb_data           (wb_data),
        .wb_next_pc        (wb_next_pc),
        .wb_mispredict     (wb_mispredict),
        .commit_valid      (commit_valid),
        .commit_inst       (commit_inst),
        .commit_pc         (commit_pc),
        .commit_data       (commit_data),
        .commit_next_pc    (commit_next_pc),
        .commit_mispredict (commit_mispredict)
    );

    retire_tracker u_tracker (
        .itf               (itf),
        .rst_n             (rst_n),
        .commit_valid      (commit_valid),
        .commit_inst       (commit_inst),
        .commit_pc         (commit_pc),
        .commit_data       (commit_data),
        .commit_next_pc    (commit_next_pc),
        .commit_mispredict (commit_mispredict),
        .retire_valid      (retire_valid),
        .retire_order      (retire_order),
        .retire_inst       (retire_inst),
        .retire_pc_rdata   (retire_pc_rdata),
        .retire_pc_wdata   (retire_pc_wdata),
        .retire_rd_addr    (retire_rd_addr),
        .retire_rd_wdata   (retire_rd_wdata),
        .retire_halt       (retire_halt),
        .rf_we             (rf_we),
        .rf_addr           (rf_addr),
        .rf_data           (rf_data),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

`default_nettype wire

/* logic/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // width of the retirement order count
    // wide enough to never wrap in practice
    localparam int order_w = 64;

    // program end marker
    // beq x0, x0, 0 spins on itself forever
    localparam logic [rv_isa_pkg::xlen-1:0] halt_inst = 32'h00000063;

endpackage

`default_nettype wire

/* logic/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // data path and pc width
    localparam int xlen = 32;

    // architectural register index width
    localparam int reg_addr_w = 5;

    // opcodes without a destination register
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // r-type field layout, msb first
    typedef struct packed {
        logic [6:0]            funct7;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [6:0]            opcode;
    } inst_r_t;

    // s-type layout, branches share it
    // rd slot carries imm bits here
    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } inst_s_t;

    // one instruction word, two decodes
    typedef union packed {
        inst_r_t r;
        inst_s_t s;
    } inst_word_u;

endpackage

`default_nettype wire
